// File: binarizer_top.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module binarizer_top
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  logic    valid_in,
    input  sample_t sample,
    input  data_t   flux_th,
    output logic    ready_out,
    output fb_wr_t  fb_wr,
    output logic    fe_complete
);

    // Input side
    logic         accept;
    logic         wr_stb;
    buf_ptr_t     wr_ptr;
    cap_t         cap;

    // Sequencing
    logic         sending;
    rd_req_t      send_rd;
    rd_req_t      cmp_tag;
    fill_ctrl_t   fill;
    row_tag_t     flux_emit;
    frame_idx_t   col_offset;

    // Buffer outputs
    lanes_t       lanes;
    data_t        old_value;
    data_t        threshold;
    feature_row_t flux_row;

    sample_capture     u_capture   (.*);
    frame_sequencer    u_sequencer (.*);
    mfcc_window_buf    u_mfcc_buf  (.*);
    mel_threshold_bank u_threshold (.*);
    flux_window_buf    u_flux_buf  (.*);
    feature_assembler  u_assembler (.*);

endmodule

// File: feature_assembler.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module feature_assembler
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  lanes_t       lanes,
    input  data_t        threshold,
    input  rd_req_t      cmp_tag,
    input  feature_row_t flux_row,
    input  row_tag_t     flux_emit,
    input  frame_idx_t   col_offset,
    output fb_wr_t       fb_wr
);

    localparam int LAST_GRP = `N_FRAME / `MFCC_LANES - 1;

    logic [`MFCC_LANES-1:0]         bits;
    logic [`N_FRAME-`MFCC_LANES-1:0] row_q;
    feature_row_t                   mfcc_raw;
    logic                           row_done;

    // Oldest column ends up in bit 0
    function automatic feature_row_t rotate_oldest(feature_row_t raw, frame_idx_t offset);
        logic [2*`N_FRAME-1:0] doubled;
        doubled = {raw, raw} >> offset;
        return doubled[`N_FRAME-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // Comparators and row collection
    // ----------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < `MFCC_LANES; b++)
            bits[b] = (lanes[b] >= threshold);
    end

    assign row_done = cmp_tag.en && (cmp_tag.group == grp_idx_t'(LAST_GRP));
    assign mfcc_raw = {bits, row_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            row_q <= '0;
        else if (cmp_tag.en && !row_done)
            row_q[cmp_tag.group*`MFCC_LANES +: `MFCC_LANES] <= bits;
    end

    // ----------------------------------------------------------------------
    // Feature bank write port
    // ----------------------------------------------------------------------
    always_comb begin
        fb_wr = '0;
        if (row_done) begin
            fb_wr.en   = 1'b1;
            fb_wr.addr = fb_addr_t'(cmp_tag.row);
            fb_wr.data = rotate_oldest(mfcc_raw, col_offset);
        end else if (flux_emit.en) begin
            // Flux rows sit above the MFCC rows
            fb_wr.en   = 1'b1;
            fb_wr.addr = fb_addr_t'(`N_MEL) + fb_addr_t'(flux_emit.row);
            fb_wr.data = rotate_oldest(flux_row, col_offset);
        end
    end

endmodule

// File: flux_window_buf.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module flux_window_buf
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         accept,
    input  logic         wr_stb,
    input  buf_ptr_t     wr_ptr,
    input  cap_t         cap,
    output feature_row_t flux_row
);

    feature_row_t flux_mem [`N_MEL];
    feature_row_t rd_q;
    feature_row_t merged;

    // Replace only the bit of the current column
    always_comb begin
        merged = rd_q;
        merged[wr_ptr.col] = cap.flux_bit;
    end

    always_ff @(posedge clk) begin
        if (accept)
            rd_q <= flux_mem[wr_ptr.row];
        if (wr_stb)
            flux_mem[wr_ptr.row] <= merged;
    end

    assign flux_row = merged;

endmodule

// File: frame_sequencer.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module frame_sequencer
    import kws_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       wr_stb,
    input  buf_ptr_t   wr_ptr,
    output logic       sending,
    output rd_req_t    send_rd,
    output rd_req_t    cmp_tag,
    output fill_ctrl_t fill,
    output row_tag_t   flux_emit,
    output frame_idx_t col_offset,
    output logic       fe_complete
);

    fe_state_t state, state_nxt;
    mel_idx_t  send_row;
    grp_idx_t  send_grp;
    rd_req_t   cmp_q;
    logic      first_frame_q, window_full_q;
    logic      frame_end, last_col, send_last;

    assign frame_end = wr_stb && (wr_ptr.row == mel_idx_t'(`N_MEL-1));
    assign last_col  = (wr_ptr.col == frame_idx_t'(`N_FRAME-1));
    assign send_last = (send_row == mel_idx_t'(`N_MEL-1)) && (send_grp == '1);

    // ----------------------------------------------------------------------
    // Frame FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_fill:        if (frame_end) state_nxt = last_col ? st_send_mfcc : st_fill_wait;
            st_fill_wait:   if (wr_stb) state_nxt = st_fill;
            st_send_mfcc:   if (send_last) state_nxt = st_send_finish;
            st_send_finish: state_nxt = st_stream_wait;
            st_stream_wait: if (wr_stb) state_nxt = st_stream;
            st_stream:      if (frame_end) state_nxt = st_send_mfcc;
            default:        state_nxt = st_fill;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_fill;
            send_row      <= '0;
            send_grp      <= '0;
            col_offset    <= '0;
            first_frame_q <= 1'b1;
            window_full_q <= 1'b0;
            cmp_q         <= '0;
        end else if (!enable) begin
            state         <= st_fill;
            send_row      <= '0;
            send_grp      <= '0;
            col_offset    <= '0;
            first_frame_q <= 1'b1;
            window_full_q <= 1'b0;
            cmp_q         <= '0;
        end else begin
            state <= state_nxt;
            cmp_q <= send_rd;
            // Eight groups per row, row steps after the last group
            if (state == st_send_mfcc) begin
                send_grp <= send_grp + 1'b1;
                if (send_grp == '1)
                    send_row <= send_row + 1'b1;
            end
            if (state == st_send_finish)
                col_offset <= col_offset + 1'b1;
            if (frame_end && wr_ptr.col == '0)
                first_frame_q <= 1'b0;
            if (frame_end && last_col)
                window_full_q <= 1'b1;
        end
    end

    assign sending = (state == st_send_mfcc) || (state == st_send_finish);
    assign send_rd = '{en: (state == st_send_mfcc), row: send_row, group: send_grp};
    assign cmp_tag = '{en: cmp_q.en && enable, row: cmp_q.row, group: cmp_q.group};
    assign fill    = '{first_frame: first_frame_q, window_full: window_full_q};

    // Flux rows start with the last column of the first window
    assign flux_emit   = '{en: wr_stb && enable && (window_full_q || last_col), row: wr_ptr.row};
    assign fe_complete = (state == st_send_finish) && enable;

endmodule

// File: kws_ctrl_pkg.sv
`include "kws_settings.svh"

package kws_ctrl_pkg;

    typedef enum logic [2:0] {
        st_fill,
        st_fill_wait,
        st_send_mfcc,
        st_send_finish,
        st_stream_wait,
        st_stream
    } fe_state_t;

    typedef logic [$clog2(`N_MEL)-1:0] mel_idx_t;
    typedef logic [$clog2(`N_FRAME)-1:0] frame_idx_t;
    typedef logic [$clog2(`N_FRAME/`MFCC_LANES)-1:0] grp_idx_t;

    typedef struct packed {
        mel_idx_t   row;
        frame_idx_t col;
    } buf_ptr_t;

    typedef struct packed {
        logic     en;
        mel_idx_t row;
        grp_idx_t group;
    } rd_req_t;

    typedef struct packed {
        logic     en;
        mel_idx_t row;
    } row_tag_t;

    typedef struct packed {
        logic first_frame;
        logic window_full;
    } fill_ctrl_t;

endpackage

// File: kws_data_pkg.sv
`include "kws_settings.svh"

package kws_data_pkg;

    typedef logic [`DATA_W-1:0] data_t;

    typedef struct packed {
        data_t mfcc;
        data_t flux;
    } sample_t;

    // Sample as held between accept and write
    typedef struct packed {
        data_t mfcc;
        logic  flux_bit;
    } cap_t;

    typedef data_t [`MFCC_LANES-1:0] lanes_t;

    typedef logic [`N_FRAME-1:0] feature_row_t;
    typedef logic [$clog2(2*`N_MEL)-1:0] fb_addr_t;

    typedef struct packed {
        logic         en;
        fb_addr_t     addr;
        feature_row_t data;
    } fb_wr_t;

endpackage

// File: kws_settings.svh
`ifndef KWS_SETTINGS_SVH
`define KWS_SETTINGS_SVH

// Window geometry
`define N_MEL      32
`define N_FRAME    64
`define DATA_W     16

// MFCC banks read side by side during a send
`define MFCC_LANES 8
`define TH_SHIFT   6

`endif

// File: mel_threshold_bank.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module mel_threshold_bank
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       accept,
    input  logic       wr_stb,
    input  buf_ptr_t   wr_ptr,
    input  cap_t       cap,
    input  data_t      old_value,
    input  fill_ctrl_t fill,
    input  rd_req_t    send_rd,
    output data_t      threshold
);

    data_t    th_mem [`N_MEL];
    data_t    rd_q;
    data_t    base, sub, sum_nxt;
    mel_idx_t rd_row;

    assign rd_row = send_rd.en ? send_rd.row : wr_ptr.row;

    // Running sum, new value in and oldest value out
    assign base    = fill.first_frame ? '0 : rd_q;
    assign sub     = fill.window_full ? (old_value >> `TH_SHIFT) : '0;
    assign sum_nxt = base + (cap.mfcc >> `TH_SHIFT) - sub;

    always_ff @(posedge clk) begin
        if (wr_stb)
            th_mem[wr_ptr.row] <= sum_nxt;
        if (accept || send_rd.en)
            rd_q <= th_mem[rd_row];
    end

    assign threshold = rd_q;

endmodule

// File: mfcc_window_buf.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module mfcc_window_buf
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     accept,
    input  logic     wr_stb,
    input  buf_ptr_t wr_ptr,
    input  cap_t     cap,
    input  rd_req_t  send_rd,
    output lanes_t   lanes,
    output data_t    old_value
);

    localparam int DEPTH = `N_MEL * `N_FRAME / `MFCC_LANES;
    localparam int AW    = $clog2(DEPTH);
    localparam int BW    = $clog2(`MFCC_LANES);

    data_t         mem [`MFCC_LANES][DEPTH];
    logic [AW-1:0] wr_addr, send_addr, rd_addr;
    logic [BW-1:0] wr_bank;
    logic          rd_en;

    // Low column bits pick the bank, upper bits the row block
    assign wr_bank   = wr_ptr.col[BW-1:0];
    assign wr_addr   = AW'((wr_ptr.col >> BW) * `N_MEL + wr_ptr.row);
    assign send_addr = AW'(send_rd.group * `N_MEL + send_rd.row);
    assign rd_addr   = send_rd.en ? send_addr : wr_addr;
    assign rd_en     = accept || send_rd.en;

    always_ff @(posedge clk) begin
        for (int b = 0; b < `MFCC_LANES; b++) begin
            if (wr_stb && wr_bank == BW'(b))
                mem[b][wr_addr] <= cap.mfcc;
            if (rd_en)
                lanes[b] <= mem[b][rd_addr];
        end
    end

    // Value leaving the window, read in the accept cycle
    assign old_value = lanes[wr_bank];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the binarizer testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary -f tb.f --top-module tb_binarizer -o tb_binarizer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_binarizer_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    exit 1
fi
exit 0

// File: sample_capture.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module sample_capture
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    input  logic     valid_in,
    input  sample_t  sample,
    input  data_t    flux_th,
    input  logic     sending,
    output logic     ready_out,
    output logic     accept,
    output logic     wr_stb,
    output buf_ptr_t wr_ptr,
    output cap_t     cap
);

    logic       ready_q;
    mel_idx_t   row_cnt;
    frame_idx_t col_cnt;

    // Handshake, one sample at most every other cycle
    assign accept    = valid_in && ready_out;
    assign ready_out = ready_q && !sending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b1;
            wr_stb  <= 1'b0;
        end else begin
            ready_q <= !accept;
            wr_stb  <= accept && enable;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap.mfcc     <= sample.mfcc;
            cap.flux_bit <= (sample.flux >= flux_th);
        end
    end

    // Write position, mel first then frame column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (!enable) begin
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (wr_stb) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_cnt == mel_idx_t'(`N_MEL-1))
                col_cnt <= col_cnt + 1'b1;
        end
    end

    assign wr_ptr = '{row: row_cnt, col: col_cnt};

endmodule

// File: tb.f
+incdir+.
kws_data_pkg.sv
kws_ctrl_pkg.sv
sample_capture.sv
frame_sequencer.sv
mfcc_window_buf.sv
mel_threshold_bank.sv
flux_window_buf.sv
feature_assembler.sv
binarizer_top.sv
tb_binarizer.sv

// File: tb_binarizer.sv
`timescale 1ns/1ns
`include "kws_settings.svh"

module tb_binarizer
    import kws_data_pkg::*;
    import kws_ctrl_pkg::*;
();

    localparam int     CLK_NS       = 40;
    localparam int     SEND_LAT     = `N_MEL * 8 + 2;
    localparam int     N_FRAMES_RUN = 201;
    localparam longint WATCHDOG_NS  =
        longint'(N_FRAMES_RUN) * (2*`N_MEL + 8*`N_MEL + 4) * CLK_NS + 1000 * CLK_NS;

    logic    clk, rst_n, enable, valid_in, ready_out, fe_complete;
    sample_t sample;
    data_t   flux_th;
    fb_wr_t  fb_wr;

    // Past frames as supplied, and the feature bank as written
    data_t        hist_mfcc [`N_FRAME][`N_MEL];
    logic         hist_flux [`N_FRAME][`N_MEL];
    feature_row_t fb_model [2*`N_MEL];

    int   seed;
    int   err_cnt, check_cnt, complete_cnt;
    int   acc_mel, acc_frame, last_mel, last_frame;
    int   wait_cnt, flux_wr_cnt, mfcc_wr_cnt;
    logic waiting, prev_accept;

    binarizer_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    // Row for one mel from the window that ends at frame newest
    function automatic feature_row_t expected_row(input logic is_flux, input int mel,
                                                  input int newest);
        feature_row_t row;
        data_t        th;
        frame_idx_t   slot;
        mel_idx_t     m;
        m  = mel_idx_t'(mel);
        th = '0;
        for (int j = 0; j < `N_FRAME; j++) begin
            slot = frame_idx_t'(newest - (`N_FRAME - 1) + j);
            th   = th + (hist_mfcc[slot][m] >> `TH_SHIFT);
        end
        for (int j = 0; j < `N_FRAME; j++) begin
            slot = frame_idx_t'(newest - (`N_FRAME - 1) + j);
            row[frame_idx_t'(j)] = is_flux ? hist_flux[slot][m] : (hist_mfcc[slot][m] >= th);
        end
        return row;
    endfunction

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_bank();
        feature_row_t exp_row;
        for (int a = 0; a < 2*`N_MEL; a++) begin
            exp_row = expected_row(a >= `N_MEL, a % `N_MEL, last_frame);
            check_cnt++;
            if (fb_model[fb_addr_t'(a)] !== exp_row)
                report_mismatch($sformatf("addr %0d expected %h actual %h",
                                          a, exp_row, fb_model[fb_addr_t'(a)]));
        end
    endtask

    task automatic clear_model_state();
        acc_mel     = 0;
        acc_frame   = 0;
        last_mel    = 0;
        last_frame  = -1;
        waiting     = 1'b0;
        wait_cnt    = 0;
        prev_accept = 1'b0;
        flux_wr_cnt = 0;
        mfcc_wr_cnt = 0;
    endtask

    // ----------------------------------------------------------------------
    // Checker sampled on the rising edge
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n || !enable) begin
            if (rst_n && (fb_wr.en || fe_complete))
                report_failure("feature bank write or fe_complete while enable is low");
            clear_model_state();
        end else begin
            if (prev_accept && ready_out)
                report_failure("ready_out high in the cycle after an accept");
            if (waiting) begin
                wait_cnt++;
                if (ready_out)
                    report_failure("ready_out high before fe_complete");
                if (wait_cnt > SEND_LAT) begin
                    report_failure("no fe_complete after the last sample of a frame");
                    waiting = 1'b0;
                end
            end
            if (fb_wr.en) begin
                fb_model[fb_wr.addr] = fb_wr.data;
                if (fb_wr.addr >= fb_addr_t'(`N_MEL)) begin
                    flux_wr_cnt++;
                    check_cnt++;
                    if (!prev_accept || last_frame < `N_FRAME - 1)
                        report_failure("flux row written outside a full-window sample");
                    else if (fb_wr.addr != fb_addr_t'(`N_MEL + last_mel))
                        report_mismatch($sformatf("flux write address expected %0d actual %0d",
                                                  `N_MEL + last_mel, fb_wr.addr));
                end else begin
                    mfcc_wr_cnt++;
                    if (!waiting)
                        report_failure("MFCC row written outside a send");
                end
            end
            if (fe_complete) begin
                complete_cnt++;
                check_cnt++;
                if (!waiting || wait_cnt != SEND_LAT)
                    report_failure("fe_complete at the wrong time");
                if (flux_wr_cnt != `N_MEL || mfcc_wr_cnt != `N_MEL)
                    report_failure($sformatf("frame gave %0d flux and %0d MFCC writes",
                                             flux_wr_cnt, mfcc_wr_cnt));
                compare_bank();
                waiting     = 1'b0;
                flux_wr_cnt = 0;
                mfcc_wr_cnt = 0;
            end
            prev_accept = valid_in && ready_out;
            if (prev_accept) begin
                hist_mfcc[frame_idx_t'(acc_frame)][mel_idx_t'(acc_mel)] = sample.mfcc;
                hist_flux[frame_idx_t'(acc_frame)][mel_idx_t'(acc_mel)] = sample.flux >= flux_th;
                last_frame = acc_frame;
                last_mel   = acc_mel;
                if (acc_mel == `N_MEL - 1) begin
                    acc_mel = 0;
                    acc_frame++;
                    // Last sample of a full window starts the send
                    if (last_frame >= `N_FRAME - 1) begin
                        waiting  = 1'b1;
                        wait_cnt = 0;
                    end
                end else begin
                    acc_mel++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic drive_samples(input int count);
        for (int i = 0; i < count; i++) begin
            valid_in = 1'b1;
            sample   = '{mfcc: data_t'($random(seed)), flux: data_t'($random(seed))};
            @(posedge clk);
            while (!ready_out)
                @(posedge clk);
            @(negedge clk);
        end
        valid_in = 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (!ready_out)
            @(posedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int err_before, input int comp_before,
                               input int exp_comp);
        check_cnt++;
        if (complete_cnt - comp_before != exp_comp)
            report_failure($sformatf("%0d fe_complete pulses, expected %0d",
                                     complete_cnt - comp_before, exp_comp));
        $display("Test %-14s %s (%0d errors)", name,
                 (err_cnt == err_before) ? "passed" : "failed", err_cnt - err_before);
    endtask

    initial begin : stimulus
        int e0;
        int c0;
        seed         = 19700;
        err_cnt      = 0;
        check_cnt    = 0;
        complete_cnt = 0;
        rst_n        = 1'b0;
        enable       = 1'b1;
        valid_in     = 1'b0;
        sample       = '0;
        flux_th      = 16'h8000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = err_cnt;
        c0 = complete_cnt;
        check_cnt++;
        if (ready_out !== 1'b1 || fb_wr.en !== 1'b0 || fe_complete !== 1'b0)
            report_failure("outputs not idle after reset");
        @(negedge clk);
        drive_samples(2 * `N_MEL);
        wait_idle();
        finish_test("reset", e0, c0, 0);

        // Remaining frames of the first window
        e0 = err_cnt;
        c0 = complete_cnt;
        drive_samples((`N_FRAME - 2) * `N_MEL);
        wait_idle();
        finish_test("fill_window", e0, c0, 1);

        e0 = err_cnt;
        c0 = complete_cnt;
        drive_samples(70 * `N_MEL);
        wait_idle();
        finish_test("streaming", e0, c0, 70);

        // Clear the window part way into a frame and keep offering samples
        e0 = err_cnt;
        c0 = complete_cnt;
        drive_samples(10);
        wait_idle();
        enable = 1'b0;
        drive_samples(20);
        flux_th = 16'h3000;
        enable  = 1'b1;
        drive_samples((`N_FRAME + 2) * `N_MEL);
        wait_idle();
        finish_test("enable_clear", e0, c0, 3);

        repeat (4) @(negedge clk);
        $display("Summary: 4 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule
